//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_mips_lite
FILELIST  = mips_lite.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = STATUS: FAIL
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/apb_loader.sv
// ########################################
// APB slave for program load and run
// CTRL/STATUS registers, memory windows
// ########################################
`default_nettype none

module apb_loader (
    input  wire                  clock,
    input  wire                  arst_n,
    input  pipe_pkg::apb_req_t   apb_req,
    output pipe_pkg::apb_rsp_t   apb_rsp,
    output pipe_pkg::host_mem_t  imem_host,
    output pipe_pkg::host_mem_t  dmem_host,
    input  isa_pkg::word_t       imem_rdata,
    input  isa_pkg::word_t       dmem_rdata,
    input  wire                  jr_seen,
    output logic                 pc_restart,
    output logic                 running,
    output logic                 done
);

    import isa_pkg::*;
    import pipe_pkg::*;

    loader_state_t state;
    logic access;
    logic wr;
    logic hit_ctrl;
    logic hit_status;
    logic hit_imem;
    logic hit_dmem;
    logic run_write;

    assign access     = apb_req.psel && apb_req.penable;
    assign wr         = access && apb_req.pwrite;
    assign hit_ctrl   = apb_req.paddr == REG_CTRL;
    assign hit_status = apb_req.paddr == REG_STATUS;
    assign hit_imem   = apb_req.paddr[11:8] == IMEM_BASE[11:8];
    assign hit_dmem   = apb_req.paddr[11:8] == DMEM_BASE[11:8];
    assign run_write  = wr && hit_ctrl && apb_req.pwdata[0];

    assign pc_restart = run_write;
    assign running    = state == ST_RUNNING;
    assign done       = state == ST_DONE;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else if (run_write) begin
            state <= ST_RUNNING;
        end else if (running && jr_seen) begin
            state <= ST_DONE;
        end
    end

    // Bank address follows paddr in setup, so read data lands in access
    assign imem_host.addr  = apb_req.paddr[7:2];
    assign imem_host.we    = wr && hit_imem && !running;
    assign imem_host.wdata = apb_req.pwdata;
    assign dmem_host.addr  = apb_req.paddr[7:2];
    assign dmem_host.we    = wr && hit_dmem && !running;
    assign dmem_host.wdata = apb_req.pwdata;

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = '0;
        if (hit_ctrl) begin
            apb_rsp.prdata = word_t'(running);
        end else if (hit_status) begin
            apb_rsp.prdata = word_t'({running, done});
        end else if (hit_imem) begin
            apb_rsp.prdata = imem_rdata;
        end else if (hit_dmem) begin
            apb_rsp.prdata = dmem_rdata;
        end
        apb_rsp.pslverr = access &&
            (!(hit_ctrl || hit_status || hit_imem || hit_dmem) ||
             (apb_req.pwrite && (hit_status || ((hit_imem || hit_dmem) && running))));
    end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
// ########################################
// Decode stage
// Control decode, register file, hazards
// ########################################
`default_nettype none

module decode_stage (
    input  wire                  clock,
    input  wire                  arst_n,
    input  pipe_pkg::if_id_t     if_id,
    input  pipe_pkg::redirect_t  redirect,
    input  pipe_pkg::mem_wb_t    mem_wb,
    input  pipe_pkg::ex_mem_t    ex_mem,
    output pipe_pkg::id_ex_t     id_ex,
    output logic                 stall
);

    import isa_pkg::*;

    word_t    regs [32];
    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    ctrl_t    ctrl;
    logic     uses_rs;
    logic     uses_rt;
    logic     wb_write;
    word_t    rs_data;
    word_t    rt_data;

    assign opcode = if_id.insn[31:26];
    assign rs     = if_id.insn[25:21];
    assign rt     = if_id.insn[20:16];
    assign funct  = if_id.insn[5:0];

    always_comb begin
        ctrl    = '0;
        uses_rt = 1'b0;
        dest    = rt;
        case (opcode)
            OP_RTYPE: begin
                dest        = if_id.insn[15:11];
                uses_rt     = 1'b1;
                ctrl.reg_we = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.alu_op = ALU_PASS;
                        ctrl.reg_we = 1'b0;
                        ctrl.is_jr  = 1'b1;
                        uses_rt     = 1'b0;
                    end
                    default: begin
                        ctrl.reg_we = 1'b0;
                        uses_rt     = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            OP_LW: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.mem_re  = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
                uses_rt      = 1'b1;
            end
            OP_BEQ: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.is_branch = 1'b1;
                uses_rt        = 1'b1;
            end
            default: ;
        endcase
    end

    assign uses_rs = ctrl.reg_we || ctrl.mem_we || ctrl.is_branch || ctrl.is_jr;

    // Register write on the edge; same-cycle reads see it through the bypass
    assign wb_write = mem_wb.valid && mem_wb.reg_we && mem_wb.rd != '0;

    always_ff @(posedge clock) begin
        if (wb_write) begin
            regs[mem_wb.rd] <= mem_wb.result;
        end
    end

    assign rs_data = (rs == '0) ? '0 :
                     (wb_write && mem_wb.rd == rs) ? mem_wb.result : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wb_write && mem_wb.rd == rt) ? mem_wb.result : regs[rt];

    function automatic logic pending(reg_idx_t idx);
        logic in_ex;
        logic in_mem;
        in_ex  = id_ex.valid && id_ex.ctrl.reg_we && id_ex.rd == idx;
        in_mem = ex_mem.valid && ex_mem.ctrl.reg_we && ex_mem.rd == idx;
        return idx != '0 && (in_ex || in_mem);
    endfunction

    assign stall = if_id.valid && ((uses_rs && pending(rs)) || (uses_rt && pending(rt)));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else begin
            // Bubble on stall, on flush or when fetch has nothing
            id_ex.valid   <= if_id.valid && !stall && !redirect.taken;
            id_ex.pc      <= if_id.pc;
            id_ex.rs_data <= rs_data;
            id_ex.rt_data <= rt_data;
            id_ex.imm     <= {{16{if_id.insn[15]}}, if_id.insn[15:0]};
            id_ex.rd      <= dest;
            id_ex.ctrl    <= ctrl;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
// ########################################
// Execute stage
// ALU, BEQ/JR resolution, EX/MEM register
// ########################################
`default_nettype none

module execute_stage (
    input  wire                  clock,
    input  wire                  arst_n,
    input  pipe_pkg::id_ex_t     id_ex,
    output pipe_pkg::ex_mem_t    ex_mem,
    output pipe_pkg::redirect_t  redirect,
    output logic                 jr_seen
);

    import isa_pkg::*;

    word_t op_b;
    word_t alu_out;
    logic  equal;

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rt_data;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  alu_out = id_ex.rs_data + op_b;
            ALU_SUB:  alu_out = id_ex.rs_data - op_b;
            ALU_AND:  alu_out = id_ex.rs_data & op_b;
            ALU_OR:   alu_out = id_ex.rs_data | op_b;
            ALU_SLT:  alu_out = word_t'($signed(id_ex.rs_data) < $signed(op_b));
            ALU_PASS: alu_out = id_ex.rs_data;
            default:  alu_out = '0;
        endcase
    end

    // No delay slot; the branch target is relative to the next PC
    assign equal           = id_ex.rs_data == id_ex.rt_data;
    assign redirect.taken  = id_ex.valid &&
                             (id_ex.ctrl.is_jr || (id_ex.ctrl.is_branch && equal));
    assign redirect.target = id_ex.ctrl.is_jr ? id_ex.rs_data :
                             id_ex.pc + 32'd4 + (id_ex.imm << 2);
    assign jr_seen         = id_ex.valid && id_ex.ctrl.is_jr;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_out;
            ex_mem.store_data <= id_ex.rt_data;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
// ########################################
// Fetch stage
// PC, instruction read, stall and redirect
// ########################################
`default_nettype none

module fetch_stage (
    input  wire                  clock,
    input  wire                  arst_n,
    input  wire                  running,
    input  wire                  pc_restart,
    input  wire                  stall,
    input  pipe_pkg::redirect_t  redirect,
    output pipe_pkg::mem_addr_t  imem_addr,
    input  isa_pkg::word_t       imem_rdata,
    output pipe_pkg::if_id_t     if_id
);

    import isa_pkg::*;

    word_t pc;
    word_t issued_pc;
    logic  issued;

    // While stalled, re-read the held word so the RAM output stays put
    assign imem_addr = stall ? issued_pc[7:2] : pc[7:2];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= '0;
            issued_pc <= '0;
            issued    <= 1'b0;
        end else if (pc_restart) begin
            pc     <= '0;
            issued <= 1'b0;
        end else if (redirect.taken) begin
            pc     <= redirect.target;
            issued <= 1'b0;
        end else if (!stall) begin
            issued    <= running;
            issued_pc <= pc;
            if (running) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign if_id.valid = issued;
    assign if_id.pc    = issued_pc;
    assign if_id.insn  = imem_rdata;

endmodule

`default_nettype wire

//--- logic/isa_pkg.sv
// ########################################
// MIPS subset instruction-set definitions
// Field types, opcode and funct codes,
// ALU operations and decoded controls
// ########################################
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type funct codes
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_we;
        logic    mem_we;
        logic    mem_re;
        logic    is_branch;
        logic    is_jr;
    } ctrl_t;

endpackage

`default_nettype wire

//--- logic/mem_bank.sv
// ########################################
// Word-addressed dual-port RAM
// Registered read on both ports
// ########################################
`default_nettype none

module mem_bank (
    input  wire                  clock,
    input  pipe_pkg::mem_addr_t  a_addr,
    input  wire                  a_we,
    input  isa_pkg::word_t       a_wdata,
    output isa_pkg::word_t       a_rdata,
    input  pipe_pkg::host_mem_t  b_req,
    output isa_pkg::word_t       b_rdata
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t mem [MEM_WORDS];

    // Host port B is written last, so it wins a same-address collision
    always_ff @(posedge clock) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        if (b_req.we) begin
            mem[b_req.addr] <= b_req.wdata;
        end
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_req.addr];
    end

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
// ########################################
// Memory stage
// Data access, result select, MEM/WB
// ########################################
`default_nettype none

module memory_stage (
    input  wire                  clock,
    input  wire                  arst_n,
    input  pipe_pkg::ex_mem_t    ex_mem,
    output pipe_pkg::mem_addr_t  dmem_addr,
    output logic                 dmem_we,
    output isa_pkg::word_t       dmem_wdata,
    input  isa_pkg::word_t       dmem_rdata,
    output pipe_pkg::mem_wb_t    mem_wb
);

    import isa_pkg::*;

    logic     wb_valid;
    logic     wb_reg_we;
    logic     wb_load;
    word_t    wb_alu;
    reg_idx_t wb_rd;

    assign dmem_addr  = ex_mem.alu_result[7:2];
    assign dmem_we    = ex_mem.valid && ex_mem.ctrl.mem_we;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid  <= 1'b0;
            wb_reg_we <= 1'b0;
            wb_load   <= 1'b0;
        end else begin
            wb_valid  <= ex_mem.valid;
            wb_reg_we <= ex_mem.ctrl.reg_we;
            wb_load   <= ex_mem.ctrl.mem_re;
        end
    end

    always_ff @(posedge clock) begin
        wb_alu <= ex_mem.alu_result;
        wb_rd  <= ex_mem.rd;
    end

    // Load data arrives from the RAM output register in the MEM/WB cycle
    assign mem_wb.valid  = wb_valid;
    assign mem_wb.result = wb_load ? dmem_rdata : wb_alu;
    assign mem_wb.rd     = wb_rd;
    assign mem_wb.reg_we = wb_reg_we;

endmodule

`default_nettype wire

//--- logic/mips_lite_top.sv
// ########################################
// mips_lite top level
// Loader, memories and pipeline stages
// ########################################
`default_nettype none

module mips_lite_top (
    input  wire                 clock,
    input  wire                 arst_n,
    input  pipe_pkg::apb_req_t  apb_req,
    output pipe_pkg::apb_rsp_t  apb_rsp,
    output logic                done
);

    import isa_pkg::*;
    import pipe_pkg::*;

    host_mem_t imem_host;
    host_mem_t dmem_host;
    word_t     imem_host_rdata;
    word_t     dmem_host_rdata;
    logic      jr_seen;
    logic      pc_restart;
    logic      running;
    logic      stall;
    mem_addr_t imem_addr;
    word_t     imem_rdata;
    mem_addr_t dmem_addr;
    logic      dmem_we;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    redirect_t redirect;

    apb_loader u_loader (
        .clock      (clock),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .imem_host  (imem_host),
        .dmem_host  (dmem_host),
        .imem_rdata (imem_host_rdata),
        .dmem_rdata (dmem_host_rdata),
        .jr_seen    (jr_seen),
        .pc_restart (pc_restart),
        .running    (running),
        .done       (done)
    );

    // Port A of the instruction bank is read only
    mem_bank u_imem (
        .clock   (clock),
        .a_addr  (imem_addr),
        .a_we    (1'b0),
        .a_wdata ('0),
        .a_rdata (imem_rdata),
        .b_req   (imem_host),
        .b_rdata (imem_host_rdata)
    );

    mem_bank u_dmem (
        .clock   (clock),
        .a_addr  (dmem_addr),
        .a_we    (dmem_we),
        .a_wdata (dmem_wdata),
        .a_rdata (dmem_rdata),
        .b_req   (dmem_host),
        .b_rdata (dmem_host_rdata)
    );

    fetch_stage u_fetch (
        .clock      (clock),
        .arst_n     (arst_n),
        .running    (running),
        .pc_restart (pc_restart),
        .stall      (stall),
        .redirect   (redirect),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clock    (clock),
        .arst_n   (arst_n),
        .if_id    (if_id),
        .redirect (redirect),
        .mem_wb   (mem_wb),
        .ex_mem   (ex_mem),
        .id_ex    (id_ex),
        .stall    (stall)
    );

    execute_stage u_execute (
        .clock    (clock),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .redirect (redirect),
        .jr_seen  (jr_seen)
    );

    memory_stage u_memory (
        .clock      (clock),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .mem_wb     (mem_wb)
    );

endmodule

`default_nettype wire

//--- logic/pipe_pkg.sv
// ########################################
// Pipeline and bus definitions
// Stage registers, APB, host port, map
// ########################################
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [5:0]  mem_addr_t;
    typedef logic [11:0] apb_addr_t;

    localparam int MEM_WORDS = 64;

    // Address map of 256-byte windows
    localparam apb_addr_t REG_CTRL   = 12'h000;
    localparam apb_addr_t REG_STATUS = 12'h004;
    localparam apb_addr_t IMEM_BASE  = 12'h100;
    localparam apb_addr_t DMEM_BASE  = 12'h200;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        reg_idx_t rd;
        logic     reg_we;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        mem_addr_t addr;
        logic      we;
        word_t     wdata;
    } host_mem_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUNNING,
        ST_DONE
    } loader_state_t;

endpackage

`default_nettype wire

//--- mips_lite.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/mem_bank.sv
logic/apb_loader.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_lite_top.sv
sim/mips_lite_chk.sv
sim/tb_mips_lite.sv

//--- sim/mips_lite_chk.sv
// ########################################
// Concurrent checks bound to mips_lite_top
// APB protocol, done and pipeline control
// ########################################
`default_nettype none

module mips_lite_chk (
    input  wire                  clock,
    input  wire                  arst_n,
    input  pipe_pkg::apb_req_t   apb_req,
    input  pipe_pkg::apb_rsp_t   apb_rsp,
    input  wire                  done,
    input  wire                  running,
    input  wire                  pc_restart,
    input  wire                  stall,
    input  pipe_pkg::redirect_t  redirect
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Access phase only after a setup cycle
    penable_after_setup: assert property (@(posedge clock) disable iff (!arst_n)
        apb_req.psel && apb_req.penable |-> $past(apb_req.psel && !apb_req.penable))
        else begin
            failures++;
            $error("APB access phase without a preceding setup cycle");
        end

    pready_high: assert property (@(posedge clock) disable iff (!arst_n)
        apb_rsp.pready)
        else begin
            failures++;
            $error("APB pready dropped low");
        end

    done_needs_run: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(done) |-> $past(running))
        else begin
            failures++;
            $error("done rose without a running program");
        end

    // Only a run write may clear done
    done_held: assert property (@(posedge clock) disable iff (!arst_n)
        done && !pc_restart |=> done)
        else begin
            failures++;
            $error("done fell without a run write");
        end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> !redirect.taken && !stall)
        else begin
            failures++;
            $error("redirect or stall active during reset");
        end

endmodule

bind mips_lite_top mips_lite_chk u_chk (
    .clock      (clock),
    .arst_n     (arst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .done       (done),
    .running    (running),
    .pc_restart (pc_restart),
    .stall      (stall),
    .redirect   (redirect)
);

`default_nettype wire

//--- sim/tb_mips_lite.sv
// ########################################
// Testbench for the mips_lite core
// APB tasks, test programs, result checks,
// watchdog and final verdict
// ########################################
`default_nettype none

module tb_mips_lite;

    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int SEED        = 66897;
    localparam int RUN_BUDGET  = 500;
    localparam int NUM_RUNS    = 5;
    localparam int WATCHDOG_NS = NUM_RUNS * RUN_BUDGET * CLK_PERIOD;

    // Instruction encodings
    localparam int OPC_BEQ   = 'h04;
    localparam int OPC_ADDIU = 'h09;
    localparam int OPC_LW    = 'h23;
    localparam int OPC_SW    = 'h2b;
    localparam int FUN_ADDU  = 'h21;
    localparam int FUN_SUBU  = 'h23;
    localparam int FUN_AND   = 'h24;
    localparam int FUN_OR    = 'h25;
    localparam int FUN_SLT   = 'h2a;

    logic     clock;
    logic     arst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     done;

    int    errors;
    int    checks;
    bit    verdict_printed;
    word_t program_words[$];

    mips_lite_top u_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .done    (done)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic word_t rtype_insn(int funct, int rd, int rs, int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, 6'(funct)};
    endfunction

    function automatic word_t itype_insn(int opcode, int rt, int rs, int imm);
        return {6'(opcode), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jr_insn(int rs);
        return {6'h00, 5'(rs), 15'h0000, 6'h08};
    endfunction

    task automatic apb_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
                                output word_t rdata, output logic slverr);
        @(negedge clock);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clock);
        apb_req.penable = 1'b1;
        // Response settles well before the closing edge
        #(CLK_PERIOD / 4);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clock);
        apb_req = '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input word_t wdata, output logic slverr);
        word_t unused;
        apb_transfer(1'b1, addr, wdata, unused, slverr);
    endtask

    task automatic apb_read(input apb_addr_t addr, output word_t rdata, output logic slverr);
        apb_transfer(1'b0, addr, '0, rdata, slverr);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERROR: %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_dmem(input string name, input int idx, input word_t expected);
        word_t rdata;
        logic  err;
        apb_read(DMEM_BASE + apb_addr_t'(4 * idx), rdata, err);
        check_value(name, expected, rdata);
    endtask

    task automatic load_program();
        logic err;
        for (int k = 0; k < program_words.size(); k++) begin
            apb_write(IMEM_BASE + apb_addr_t'(4 * k), program_words[k], err);
        end
    endtask

    task automatic start_run();
        logic err;
        apb_write(REG_CTRL, 32'd1, err);
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < RUN_BUDGET) begin
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            errors++;
            $display("Program %s did not finish within %0d cycles", name, RUN_BUDGET);
        end
    endtask

    task automatic run_program(input string name);
        load_program();
        start_run();
        wait_done(name);
    endtask

    initial begin
        word_t       a;
        word_t       b;
        word_t       r;
        word_t       c;
        word_t       t2;
        word_t       t4;
        word_t       t5;
        word_t       marker;
        word_t       protect;
        word_t       rdata;
        word_t       imm_ext;
        logic [15:0] imm;
        logic        err;
        int          idx;
        int          assert_fails;

        clock           = 1'b0;
        arst_n          = 1'b0;
        apb_req         = '0;
        errors          = 0;
        checks          = 0;
        verdict_printed = 1'b0;
        void'($urandom(SEED));
        repeat (16) @(negedge clock);
        arst_n = 1'b1;

        // Register access and memory windows
        apb_read(REG_STATUS, rdata, err);
        check_value("status after reset", 32'd0, rdata);
        apb_read(12'h300, rdata, err);
        check_value("unmapped read slverr", 32'd1, word_t'(err));
        apb_write(REG_STATUS, 32'd1, err);
        check_value("status write slverr", 32'd1, word_t'(err));
        for (int k = 0; k < 3; k++) begin
            idx = k * 31;
            r = $urandom();
            apb_write(IMEM_BASE + apb_addr_t'(4 * idx), r, err);
            check_value("imem write slverr", 32'd0, word_t'(err));
            apb_read(IMEM_BASE + apb_addr_t'(4 * idx), rdata, err);
            check_value("imem readback", r, rdata);
            apb_write(DMEM_BASE + apb_addr_t'(4 * idx), ~r, err);
            check_value("dmem write slverr", 32'd0, word_t'(err));
            apb_read(DMEM_BASE + apb_addr_t'(4 * idx), rdata, err);
            check_value("dmem readback", ~r, rdata);
        end

        // Arithmetic on random operands
        a = $urandom();
        b = $urandom();
        r = $urandom();
        imm = r[15:0];
        imm_ext = {{16{imm[15]}}, imm};
        apb_write(DMEM_BASE, a, err);
        apb_write(DMEM_BASE + 12'h004, b, err);
        program_words.delete();
        program_words.push_back(itype_insn(OPC_LW, 1, 0, 0));
        program_words.push_back(itype_insn(OPC_LW, 2, 0, 4));
        program_words.push_back(rtype_insn(FUN_ADDU, 3, 1, 2));
        program_words.push_back(rtype_insn(FUN_SUBU, 4, 1, 2));
        program_words.push_back(rtype_insn(FUN_AND, 5, 1, 2));
        program_words.push_back(rtype_insn(FUN_OR, 6, 1, 2));
        program_words.push_back(rtype_insn(FUN_SLT, 7, 1, 2));
        program_words.push_back(itype_insn(OPC_ADDIU, 8, 1, int'(imm)));
        for (int k = 3; k <= 8; k++) begin
            program_words.push_back(itype_insn(OPC_SW, k, 0, 4 * (k - 1)));
        end
        program_words.push_back(jr_insn(0));
        run_program("arithmetic");
        check_dmem("addu", 2, a + b);
        check_dmem("subu", 3, a - b);
        check_dmem("and", 4, a & b);
        check_dmem("or", 5, a | b);
        check_dmem("slt", 6, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        check_dmem("addiu", 7, a + imm_ext);

        // Dependent chain and load-use pairs
        c = $urandom();
        t2 = c + 32'd5;
        t4 = t2 + t2 - c - 32'd3;
        t5 = t4 | t2;
        apb_write(DMEM_BASE + 12'h020, c, err);
        program_words.delete();
        program_words.push_back(itype_insn(OPC_LW, 1, 0, 32));
        program_words.push_back(itype_insn(OPC_ADDIU, 2, 1, 5));
        program_words.push_back(rtype_insn(FUN_ADDU, 3, 2, 2));
        program_words.push_back(rtype_insn(FUN_SUBU, 4, 3, 1));
        program_words.push_back(itype_insn(OPC_ADDIU, 4, 4, -3));
        program_words.push_back(rtype_insn(FUN_OR, 5, 4, 2));
        program_words.push_back(itype_insn(OPC_SW, 5, 0, 36));
        program_words.push_back(itype_insn(OPC_SW, 4, 0, 40));
        program_words.push_back(itype_insn(OPC_LW, 6, 0, 36));
        program_words.push_back(itype_insn(OPC_ADDIU, 7, 6, 1));
        program_words.push_back(itype_insn(OPC_SW, 7, 0, 44));
        program_words.push_back(jr_insn(0));
        run_program("hazards");
        check_dmem("chain or result", 9, t5);
        check_dmem("chain addiu result", 10, t4);
        check_dmem("load-use result", 11, t5 + 32'd1);

        // Not-taken and taken BEQ with a marker behind the taken one
        marker = $urandom();
        apb_write(DMEM_BASE + 12'h030, marker, err);
        apb_write(DMEM_BASE + 12'h034, 32'd0, err);
        apb_write(DMEM_BASE + 12'h038, 32'd0, err);
        program_words.delete();
        program_words.push_back(itype_insn(OPC_ADDIU, 1, 0, 7));
        program_words.push_back(itype_insn(OPC_ADDIU, 2, 0, 7));
        program_words.push_back(itype_insn(OPC_ADDIU, 3, 0, 9));
        program_words.push_back(itype_insn(OPC_BEQ, 3, 1, 2));
        program_words.push_back(itype_insn(OPC_ADDIU, 4, 0, 'h55));
        program_words.push_back(itype_insn(OPC_SW, 4, 0, 52));
        program_words.push_back(itype_insn(OPC_BEQ, 2, 1, 3));
        program_words.push_back(itype_insn(OPC_SW, 0, 0, 48));
        program_words.push_back(itype_insn(OPC_SW, 1, 0, 48));
        program_words.push_back(itype_insn(OPC_SW, 3, 0, 48));
        program_words.push_back(itype_insn(OPC_ADDIU, 5, 0, 'h66));
        program_words.push_back(itype_insn(OPC_SW, 5, 0, 56));
        program_words.push_back(jr_insn(0));
        run_program("branches");
        check_dmem("taken beq marker", 12, marker);
        check_dmem("not-taken beq path", 13, 32'h55);
        check_dmem("taken beq target", 14, 32'h66);

        // Protection while running and a second run
        protect = $urandom();
        apb_write(DMEM_BASE + 12'h050, protect, err);
        start_run();
        apb_write(DMEM_BASE + 12'h050, ~protect, err);
        check_value("write during run slverr", 32'd1, word_t'(err));
        apb_read(REG_STATUS, rdata, err);
        check_value("status while running", 32'd2, rdata);
        wait_done("protection run");
        apb_read(REG_STATUS, rdata, err);
        check_value("status after done", 32'd1, rdata);
        check_dmem("protected word", 20, protect);
        start_run();
        apb_read(REG_STATUS, rdata, err);
        check_value("status after rerun", 32'd2, rdata);
        wait_done("second run");
        apb_read(REG_STATUS, rdata, err);
        check_value("status after second done", 32'd1, rdata);

        assert_fails = u_dut.u_chk.failures;
        verdict_printed = 1'b1;
        $display("Checks: %0d  Errors: %0d  Assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        verdict_printed = 1'b1;
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    final begin
        if (!verdict_printed) begin
            $display("Simulation stopped before the tests completed");
            $display("STATUS: FAIL");
        end
    end

endmodule

`default_nettype wire
